// File: project.f
+incdir+include
rtl/riscv_isa_pkg.sv
rtl/branch_pred_pkg.sv
rtl/branch_interfaces.sv
rtl/branch_decode.sv
rtl/branch_execute.sv
rtl/branch_table.sv
rtl/return_stack.sv
rtl/branch_unit_top.sv
testbench/branch_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the branch unit testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module branch_unit_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vbranch_unit_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'NO ERRORS'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: testbench/branch_unit_tb.sv
// Branch unit testbench: directed and random resolutions checked against a reference model.
`default_nettype none
`include "bp_config.svh"

module branch_unit_tb import riscv_isa_pkg::*, branch_pred_pkg::*; ();

    localparam int IDX_W          = $clog2(`BRANCH_TABLE_ENTRIES);
    localparam int NUM_OPS        = 400;
    localparam int CYCLES_PER_OP  = 3;
    localparam int TIMEOUT_CYCLES = NUM_OPS * CYCLES_PER_OP + 300;

    logic        clk;
    logic        rst;
    logic        fetch_req;
    addr_t       fetch_pc;
    logic        ex_valid;
    addr_t       ex_pc;
    logic [31:0] ex_instr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    addr_t       dec_pc;
    addr_t       predicted_pc;
    logic        prediction;
    logic        use_prediction;
    logic        use_ras;
    addr_t       ras_addr;
    logic        ras_valid;
    logic        flush;
    addr_t       redirect_pc;
    miss_count_t br_miss_count;
    miss_count_t ret_miss_count;

    int          errors;
    int          checks;
    int          cycles = 0;
    logic [31:0] rng_state;

    // Reference model of table, stack and counters.
    logic        model_on;
    logic        model_valid  [`BRANCH_TABLE_ENTRIES];
    addr_t       model_tag    [`BRANCH_TABLE_ENTRIES];
    logic        model_pred   [`BRANCH_TABLE_ENTRIES];
    logic        model_ras    [`BRANCH_TABLE_ENTRIES];
    addr_t       model_target [`BRANCH_TABLE_ENTRIES];
    addr_t       ras_model [$];
    miss_count_t model_br_miss;
    miss_count_t model_ret_miss;

    branch_unit_top DUT (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic link_reg(reg_idx_t r);
        return (r == LINK_REG_RA) || (r == LINK_REG_T0);
    endfunction

    // B-type with rs1 = x10 and rs2 = x11.
    function automatic logic [31:0] branch_word(branch_cond_t c, logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd11, 5'd10, c, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(reg_idx_t rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] jalr_word(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_JALR};
    endfunction

    function automatic logic branch_outcome(branch_cond_t c, logic [31:0] a, logic [31:0] b);
        case (c)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            BGEU:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_addr(string name, addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(string name, miss_count_t got, miss_count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Fetch lookup, result visible one cycle later.
    task automatic lookup_fetch(addr_t pc);
        int   idx;
        logic hit;
        idx = int'(pc[IDX_W+1:2]);
        hit = model_on && model_valid[idx] && (model_tag[idx] == (pc >> (IDX_W + 2)));
        fetch_req = 1'b1;
        fetch_pc  = pc;
        @(posedge clk);
        @(negedge clk);
        fetch_req = 1'b0;
        check_bit("use_prediction", use_prediction, (`USE_BRANCH_PREDICTOR != 0) && hit);
        check_bit("prediction", prediction, hit && model_pred[idx]);
        check_bit("use_ras", use_ras, hit && model_ras[idx]);
        if (hit) begin
            check_addr("predicted_pc", predicted_pc, model_target[idx]);
        end
    endtask

    // One executed branch: resolve cycle checks, then state after the write edge.
    task automatic resolve_branch(logic [31:0] instr, addr_t pc, logic [31:0] a,
                                  logic [31:0] b, addr_t dpc, logic taken, addr_t target);
        addr_t actual;
        logic  miss;
        logic  call;
        logic  ret;
        int    idx;
        actual = taken ? target : pc + 32'd4;
        miss   = (dpc != actual);
        call   = ((instr[6:0] == OPC_JAL) || (instr[6:0] == OPC_JALR)) && link_reg(instr[11:7]);
        ret    = (instr[6:0] == OPC_JALR) && link_reg(instr[19:15]) && !link_reg(instr[11:7]);
        idx    = int'(pc[IDX_W+1:2]);
        ex_valid = 1'b1;
        ex_pc    = pc;
        ex_instr = instr;
        rs1_data = a;
        rs2_data = b;
        dec_pc   = dpc;
        @(posedge clk);
        @(negedge clk);
        ex_valid = 1'b0;
        check_bit("flush", flush, (`USE_BRANCH_PREDICTOR != 0) ? miss : taken);
        check_addr("redirect_pc", redirect_pc, actual);
        model_on          = 1'b1;
        model_valid[idx]  = 1'b1;
        model_tag[idx]    = pc >> (IDX_W + 2);
        model_pred[idx]   = taken;
        model_ras[idx]    = ret;
        model_target[idx] = actual;
        if (miss && ret) begin
            model_ret_miss = model_ret_miss + 1;
        end else if (miss) begin
            model_br_miss = model_br_miss + 1;
        end
        if (ret && (ras_model.size() != 0)) begin
            void'(ras_model.pop_back());
        end
        if (call) begin
            ras_model.push_back(pc + 32'd4);
            if (ras_model.size() > `RAS_DEPTH) begin
                void'(ras_model.pop_front());
            end
        end
        @(posedge clk);
        @(negedge clk);
        check_count("br_miss_count", br_miss_count, model_br_miss);
        check_count("ret_miss_count", ret_miss_count, model_ret_miss);
        check_bit("ras_valid", ras_valid, ras_model.size() != 0);
        if (ras_model.size() != 0) begin
            check_addr("ras_addr", ras_addr, ras_model[$]);
        end
    endtask

    task automatic reset_state_check();
        check_bit("flush", flush, 1'b0);
        check_bit("use_prediction", use_prediction, 1'b0);
        check_count("br_miss_count", br_miss_count, 32'd0);
        check_count("ret_miss_count", ret_miss_count, 32'd0);
        check_bit("ras_valid", ras_valid, 1'b0);
    endtask

    task automatic random_conditionals(int count);
        branch_cond_t conds [6];
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  r;
        logic [12:0]  imm;
        addr_t        pc;
        addr_t        target;
        addr_t        dpc;
        conds = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        for (int i = 0; i < count; i++) begin
            a = next_random();
            b = next_random();
            r = next_random();
            // Equal operands now and then.
            if (r[1:0] == 2'b00) begin
                b = a;
            end
            pc     = next_random() & 32'hffff_fffc;
            imm    = {r[13:2], 1'b0};
            target = pc + {{19{imm[12]}}, imm};
            case (r[20:19])
                2'd0:    dpc = pc + 32'd4;
                2'd1:    dpc = target;
                default: dpc = next_random() & 32'hffff_fffc;
            endcase
            resolve_branch(branch_word(conds[i % 6], imm), pc, a, b, dpc,
                           branch_outcome(conds[i % 6], a, b), target);
        end
    endtask

    task automatic jump_targets();
        resolve_branch(jal_word(5'd0, 21'h000800), 32'h0000_1000, 32'd0, 32'd0,
                       32'h0000_1800, 1'b1, 32'h0000_1800);
        // Backward jump.
        resolve_branch(jal_word(5'd0, 21'h1ff000), 32'h0000_3000, 32'd0, 32'd0,
                       32'h0000_3004, 1'b1, 32'h0000_2000);
        // Odd sums lose bit 0.
        resolve_branch(jalr_word(5'd0, 5'd10, 12'h004), 32'h0000_4000, 32'h0000_2001, 32'd0,
                       32'h0000_2004, 1'b1, 32'h0000_2004);
        resolve_branch(jalr_word(5'd0, 5'd10, 12'hfff), 32'h0000_4100, 32'h0000_5000, 32'd0,
                       32'h0000_4ffe, 1'b1, 32'h0000_4ffe);
        resolve_branch(branch_word(BNE, 13'h040), 32'h0000_6000, 32'd9, 32'd9,
                       32'h0000_6040, 1'b0, 32'h0000_6040);
    endtask

    task automatic table_learning();
        addr_t p;
        p = 32'h0000_4a40;
        resolve_branch(branch_word(BEQ, 13'h100), p, 32'd7, 32'd7, p + 32'd4, 1'b1, p + 32'h100);
        lookup_fetch(p);
        check_bit("use_prediction", use_prediction, 1'b1);
        check_bit("prediction", prediction, 1'b1);
        check_addr("predicted_pc", predicted_pc, p + 32'h100);
        // Same index, different tag.
        lookup_fetch(p + 32'h100);
        check_bit("use_prediction", use_prediction, 1'b0);
        // Opposite outcome replaces the entry.
        resolve_branch(branch_word(BEQ, 13'h100), p, 32'd7, 32'd8, p + 32'h100, 1'b0, p + 32'h100);
        lookup_fetch(p);
        check_bit("prediction", prediction, 1'b0);
        check_addr("predicted_pc", predicted_pc, p + 32'd4);
    endtask

    task automatic return_stack_order();
        addr_t ret_addr;
        resolve_branch(jal_word(LINK_REG_RA, 21'h001000), 32'h0000_8000, 32'd0, 32'd0,
                       32'h0000_9000, 1'b1, 32'h0000_9000);
        check_addr("ras_addr", ras_addr, 32'h0000_8004);
        resolve_branch(jal_word(LINK_REG_T0, 21'h001000), 32'h0000_9010, 32'd0, 32'd0,
                       32'h0000_a010, 1'b1, 32'h0000_a010);
        check_addr("ras_addr", ras_addr, 32'h0000_9014);
        resolve_branch(jalr_word(LINK_REG_RA, 5'd10, 12'h000), 32'h0000_a020, 32'h0000_b000,
                       32'd0, 32'h0000_b000, 1'b1, 32'h0000_b000);
        check_addr("ras_addr", ras_addr, 32'h0000_a024);
        // Returns unwind in reverse order, the middle one mispredicted.
        resolve_branch(jalr_word(5'd0, LINK_REG_RA, 12'h000), 32'h0000_b000, 32'h0000_a024,
                       32'd0, 32'h0000_a024, 1'b1, 32'h0000_a024);
        check_addr("ras_addr", ras_addr, 32'h0000_9014);
        resolve_branch(jalr_word(5'd0, LINK_REG_T0, 12'h000), 32'h0000_a024, 32'h0000_9014,
                       32'd0, 32'h0000_a028, 1'b1, 32'h0000_9014);
        check_addr("ras_addr", ras_addr, 32'h0000_8004);
        resolve_branch(jalr_word(5'd0, LINK_REG_RA, 12'h000), 32'h0000_9014, 32'h0000_8004,
                       32'd0, 32'h0000_8004, 1'b1, 32'h0000_8004);
        check_bit("ras_valid", ras_valid, 1'b0);
        lookup_fetch(32'h0000_b000);
        check_bit("use_ras", use_ras, 1'b1);
        // Overflow, then pop past empty.
        for (int i = 0; i < `RAS_DEPTH + 2; i++) begin
            resolve_branch(jal_word(LINK_REG_RA, 21'h000100), 32'h0001_0000 + 32'(i * 16),
                           32'd0, 32'd0, 32'h0001_0100 + 32'(i * 16), 1'b1,
                           32'h0001_0100 + 32'(i * 16));
        end
        for (int i = 0; i < `RAS_DEPTH + 3; i++) begin
            ret_addr = (ras_model.size() != 0) ? ras_model[$] : 32'h0000_0100;
            resolve_branch(jalr_word(5'd0, LINK_REG_RA, 12'h000), 32'h0002_0000, ret_addr,
                           32'd0, ret_addr, 1'b1, ret_addr);
        end
        check_bit("ras_valid", ras_valid, 1'b0);
    endtask

    task automatic miss_counting();
        miss_count_t base_br;
        miss_count_t base_ret;
        base_br  = model_br_miss;
        base_ret = model_ret_miss;
        resolve_branch(branch_word(BLTU, 13'h020), 32'h0000_c000, 32'd1, 32'd2,
                       32'h0000_c004, 1'b1, 32'h0000_c020);
        resolve_branch(branch_word(BGE, 13'h020), 32'h0000_c040, 32'hffff_fff0, 32'd3,
                       32'h0000_c044, 1'b0, 32'h0000_c060);
        resolve_branch(jal_word(LINK_REG_RA, 21'h000100), 32'h0000_c100, 32'd0, 32'd0,
                       32'h0000_c104, 1'b1, 32'h0000_c200);
        resolve_branch(jal_word(LINK_REG_RA, 21'h000100), 32'h0000_c300, 32'd0, 32'd0,
                       32'h0000_c400, 1'b1, 32'h0000_c400);
        resolve_branch(jalr_word(5'd0, LINK_REG_RA, 12'h000), 32'h0000_d000, 32'h0000_c304,
                       32'd0, 32'h0000_d004, 1'b1, 32'h0000_c304);
        resolve_branch(jalr_word(5'd0, LINK_REG_RA, 12'h000), 32'h0000_d100, 32'h0000_c104,
                       32'd0, 32'h0000_c104, 1'b1, 32'h0000_c104);
        check_count("br_miss_count", br_miss_count, base_br + 32'd2);
        check_count("ret_miss_count", ret_miss_count, base_ret + 32'd1);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        fetch_req = 1'b0;
        fetch_pc  = '0;
        ex_valid  = 1'b0;
        ex_pc     = '0;
        ex_instr  = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        dec_pc    = '0;
        rng_state = 32'hbafe0694;
        errors    = 0;
        checks    = 0;
        model_on       = 1'b0;
        model_br_miss  = '0;
        model_ret_miss = '0;
        for (int i = 0; i < `BRANCH_TABLE_ENTRIES; i++) begin
            model_valid[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_state_check();
        random_conditionals(120);
        jump_targets();
        table_learning();
        return_stack_order();
        miss_counting();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/branch_unit_top.sv
// Branch unit top: decode, execute, target table and return stack behind plain ports.
`default_nettype none

module branch_unit_top import riscv_isa_pkg::*, branch_pred_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_req,
    input  addr_t       fetch_pc,
    input  logic        ex_valid,
    input  addr_t       ex_pc,
    input  logic [31:0] ex_instr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  addr_t       dec_pc,
    output addr_t       predicted_pc,
    output logic        prediction,
    output logic        use_prediction,
    output logic        use_ras,
    output addr_t       ras_addr,
    output logic        ras_valid,
    output logic        flush,
    output addr_t       redirect_pc,
    output miss_count_t br_miss_count,
    output miss_count_t ret_miss_count
);

    branch_decode_if  dec_bus ();
    branch_resolve_if res_bus ();
    ras_if            ras_bus ();

    branch_decode u_decode (
        .instr (ex_instr),
        .pc    (ex_pc),
        .valid (ex_valid),
        .dec   (dec_bus.decoder)
    );

    branch_execute u_execute (
        .clk      (clk),
        .rst      (rst),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec_pc   (dec_pc),
        .dec      (dec_bus.exec),
        .res      (res_bus.exec)
    );

    branch_table u_table (
        .clk            (clk),
        .rst            (rst),
        .fetch_req      (fetch_req),
        .fetch_pc       (fetch_pc),
        .predicted_pc   (predicted_pc),
        .prediction     (prediction),
        .use_prediction (use_prediction),
        .use_ras        (use_ras),
        .flush          (flush),
        .res            (res_bus.bt),
        .br_miss_count  (br_miss_count),
        .ret_miss_count (ret_miss_count)
    );

    return_stack u_ras (
        .clk (clk),
        .rst (rst),
        .res (res_bus.ras),
        .ras (ras_bus.stack)
    );

    // Actual next pc of the resolved branch.
    assign redirect_pc = res_bus.taken ? res_bus.jump_pc : res_bus.njump_pc;

    assign ras_addr  = ras_bus.top;
    assign ras_valid = ras_bus.nonempty;

endmodule

`default_nettype wire

// File: rtl/return_stack.sv
// Return address stack: circular buffer pushed on calls and popped on returns.
`default_nettype none
`include "bp_config.svh"

module return_stack import riscv_isa_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    branch_resolve_if.ras    res,
    ras_if.stack             ras
);

    localparam int              PTR_W       = $clog2(`RAS_DEPTH);
    localparam logic [PTR_W:0]  DEPTH_COUNT = `RAS_DEPTH;

    addr_t            stack_mem [`RAS_DEPTH];
    logic [PTR_W-1:0] top_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             pop_ok;
    logic [PTR_W-1:0] base_ptr;
    logic [PTR_W:0]   base_count;
    logic [PTR_W-1:0] push_ptr;

    assign do_push = res.branch_ex & res.is_call;
    // Pop on empty is ignored.
    assign pop_ok  = res.branch_ex & res.is_return & (count != '0);

    // Pop is applied first, then the push on top of it.
    assign base_ptr   = pop_ok ? top_ptr - 1'b1 : top_ptr;
    assign base_count = pop_ok ? count - 1'b1 : count;
    assign push_ptr   = base_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            top_ptr <= '0;
            count   <= '0;
        end else if (do_push) begin
            top_ptr <= push_ptr;
            // Full stack overwrites its oldest entry.
            count   <= (base_count == DEPTH_COUNT) ? base_count : base_count + 1'b1;
        end else if (pop_ok) begin
            top_ptr <= base_ptr;
            count   <= base_count;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_mem[push_ptr] <= res.njump_pc;
        end
    end

    assign ras.top      = stack_mem[top_ptr];
    assign ras.nonempty = (count != '0);

    count_in_range: assert property (@(posedge clk) disable iff (rst) count <= DEPTH_COUNT);

endmodule

`default_nettype wire

// File: rtl/branch_table.sv
// Branch target table: learns resolved targets, predicts on fetch and counts mispredicts.
`default_nettype none
`include "bp_config.svh"

module branch_table import riscv_isa_pkg::*, branch_pred_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            fetch_req,
    input  addr_t           fetch_pc,
    output addr_t           predicted_pc,
    output logic            prediction,
    output logic            use_prediction,
    output logic            use_ras,
    output logic            flush,
    branch_resolve_if.bt    res,
    output miss_count_t     br_miss_count,
    output miss_count_t     ret_miss_count
);

    bt_entry_t tag_ram    [`BRANCH_TABLE_ENTRIES];
    addr_t     target_ram [`BRANCH_TABLE_ENTRIES];

    logic [`BRANCH_TABLE_ENTRIES-1:0] valid_bits;

    logic [BT_INDEX_W-1:0] fetch_idx;
    logic [BT_INDEX_W-1:0] ex_idx;
    bt_entry_t             ex_entry;
    bt_entry_t             lookup_entry;
    logic                  lookup_valid;
    addr_t                 lookup_pc;
    addr_t                 actual_pc;
    logic                  tag_match;
    logic                  hit;
    logic                  mispredict;
    logic                  bt_on;

    assign fetch_idx = fetch_pc[BT_INDEX_W+1:2];
    assign ex_idx    = res.ex_pc[BT_INDEX_W+1:2];
    assign actual_pc = res.taken ? res.jump_pc : res.njump_pc;

    // Next time, predict the same direction and target.
    assign ex_entry.valid      = 1'b1;
    assign ex_entry.tag        = res.ex_pc[31:BT_INDEX_W+2];
    assign ex_entry.prediction = res.taken;
    assign ex_entry.use_ras    = res.is_return;

    always_ff @(posedge clk) begin
        if (res.branch_ex) begin
            tag_ram[ex_idx]    <= ex_entry;
            target_ram[ex_idx] <= actual_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (res.branch_ex) begin
            valid_bits[ex_idx] <= 1'b1;
        end
    end

    // Fetch lookup, a write in the same cycle is not seen.
    always_ff @(posedge clk) begin
        if (fetch_req) begin
            lookup_entry <= tag_ram[fetch_idx];
            predicted_pc <= target_ram[fetch_idx];
            lookup_pc    <= fetch_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_valid <= 1'b0;
        end else if (fetch_req) begin
            lookup_valid <= valid_bits[fetch_idx];
        end
    end

    // Table stays off until the first branch resolves.
    always_ff @(posedge clk) begin
        if (rst) begin
            bt_on <= 1'b0;
        end else if (res.branch_ex) begin
            bt_on <= 1'b1;
        end
    end

    assign tag_match = (lookup_entry.tag == lookup_pc[31:BT_INDEX_W+2]);
    assign hit       = bt_on & lookup_valid & lookup_entry.valid & tag_match;

    assign mispredict = res.branch_ex && (res.dec_pc != actual_pc);

    if (`USE_BRANCH_PREDICTOR != 0) begin : g_predict
        assign use_prediction = hit;
        assign flush          = mispredict;
    end else begin : g_no_predict
        assign use_prediction = 1'b0;
        assign flush          = res.branch_ex & res.taken;
    end

    assign prediction = hit & lookup_entry.prediction;
    assign use_ras    = hit & lookup_entry.use_ras;

    always_ff @(posedge clk) begin
        if (rst) begin
            br_miss_count  <= '0;
            ret_miss_count <= '0;
        end else if (mispredict) begin
            if (res.is_return) begin
                ret_miss_count <= ret_miss_count + 1'b1;
            end else begin
                br_miss_count <= br_miss_count + 1'b1;
            end
        end
    end

    // Return entries always predict taken.
    ras_hint_taken: assert property (
        @(posedge clk) disable iff (rst) use_ras |-> prediction
    );

endmodule

`default_nettype wire

// File: rtl/branch_execute.sv
// Branch execute: compares operands, forms both targets and registers the resolution.
`default_nettype none

module branch_execute import riscv_isa_pkg::*, branch_pred_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       rs1_data,
    input  logic [31:0]       rs2_data,
    input  addr_t             dec_pc,
    branch_decode_if.exec     dec,
    branch_resolve_if.exec    res
);

    logic        cond_taken;
    logic        taken;
    logic        is_branch;
    logic [31:0] jalr_sum;
    addr_t       jump_pc;
    addr_t       njump_pc;

    always_comb begin
        case (dec.info.cond)
            BEQ:     cond_taken = (rs1_data == rs2_data);
            BNE:     cond_taken = (rs1_data != rs2_data);
            BLT:     cond_taken = ($signed(rs1_data) < $signed(rs2_data));
            BGE:     cond_taken = ($signed(rs1_data) >= $signed(rs2_data));
            BLTU:    cond_taken = (rs1_data < rs2_data);
            BGEU:    cond_taken = (rs1_data >= rs2_data);
            default: cond_taken = 1'b0;
        endcase
    end

    // Jumps are always taken.
    assign taken = (dec.info.op == BR_COND) ? cond_taken : 1'b1;

    assign is_branch = dec.valid && (dec.info.op != BR_NONE);

    // JALR target has bit 0 cleared.
    assign jalr_sum = rs1_data + dec.info.imm;
    assign jump_pc  = (dec.info.op == BR_JALR) ? {jalr_sum[31:1], 1'b0} : dec.pc + dec.info.imm;
    assign njump_pc = dec.pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            res.branch_ex <= 1'b0;
        end else begin
            res.branch_ex <= is_branch;
        end
    end

    // Resolution record, held until the next executed instruction.
    always_ff @(posedge clk) begin
        if (dec.valid) begin
            res.ex_pc     <= dec.pc;
            res.jump_pc   <= jump_pc;
            res.njump_pc  <= njump_pc;
            res.taken     <= taken;
            res.is_call   <= dec.info.is_call;
            res.is_return <= dec.info.is_return;
            res.dec_pc    <= dec_pc;
        end
    end

    // Calls and returns always resolve taken.
    call_return_taken: assert property (
        @(posedge clk) disable iff (rst)
        res.branch_ex && (res.is_call || res.is_return) |-> res.taken
    );

endmodule

`default_nettype wire

// File: rtl/branch_decode.sv
// Branch decoder: classifies the execute-stage instruction and extracts its immediate.
`default_nettype none

module branch_decode import riscv_isa_pkg::*, branch_pred_pkg::*; (
    input  logic [31:0]        instr,
    input  addr_t              pc,
    input  logic               valid,
    branch_decode_if.decoder   dec
);

    opcode_t         opcode;
    reg_idx_t        rd;
    reg_idx_t        rs1;
    logic            rd_link;
    logic            rs1_link;
    logic            cond_ok;
    decoded_branch_t info;

    function automatic logic is_link(reg_idx_t r);
        return (r == LINK_REG_RA) || (r == LINK_REG_T0);
    endfunction

    assign rd       = instr[11:7];
    assign rs1      = instr[19:15];
    assign rd_link  = is_link(rd);
    assign rs1_link = is_link(rs1);

    // funct3 010 and 011 are not branch conditions.
    assign cond_ok = (instr[14:13] != 2'b01);

    always_comb begin
        case (instr[6:0])
            OPC_BRANCH: opcode = OPC_BRANCH;
            OPC_JAL:    opcode = OPC_JAL;
            OPC_JALR:   opcode = OPC_JALR;
            default:    opcode = OPC_OTHER;
        endcase
    end

    always_comb begin
        info      = '0;
        info.op   = BR_NONE;
        info.cond = branch_cond_t'(instr[14:12]);
        case (opcode)
            OPC_BRANCH: begin
                if (cond_ok) begin
                    info.op = BR_COND;
                end
                info.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                info.op      = BR_JAL;
                info.imm     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                info.is_call = rd_link;
            end
            OPC_JALR: begin
                info.op        = BR_JALR;
                info.imm       = {{20{instr[31]}}, instr[31:20]};
                info.is_call   = rd_link;
                info.is_return = rs1_link & ~rd_link;
            end
            default: begin
                info.op = BR_NONE;
            end
        endcase
    end

    assign dec.valid = valid;
    assign dec.info  = info;
    assign dec.pc    = pc;

endmodule

`default_nettype wire

// File: rtl/branch_interfaces.sv
// Interfaces between decode, execute, target table and return stack.
`default_nettype none

// Decoded execute-stage instruction.
interface branch_decode_if import riscv_isa_pkg::*, branch_pred_pkg::*; ();
    logic            valid;
    decoded_branch_t info;
    addr_t           pc;

    modport decoder (output valid, info, pc);
    modport exec (input valid, info, pc);
endinterface

// Registered branch resolution, one cycle after execute.
interface branch_resolve_if import riscv_isa_pkg::*; ();
    logic  branch_ex;
    addr_t ex_pc;
    addr_t jump_pc;
    addr_t njump_pc;
    logic  taken;
    logic  is_call;
    logic  is_return;
    addr_t dec_pc;

    modport exec (
        output branch_ex, ex_pc, jump_pc, njump_pc, taken, is_call, is_return, dec_pc
    );
    modport bt (
        input branch_ex, ex_pc, jump_pc, njump_pc, taken, is_call, is_return, dec_pc
    );
    modport ras (input branch_ex, njump_pc, is_call, is_return);
endinterface

// Top of the return address stack.
interface ras_if import riscv_isa_pkg::*; ();
    addr_t top;
    logic  nonempty;

    modport stack (output top, nonempty);
    modport bt (input top, nonempty);
endinterface

`default_nettype wire

// File: rtl/branch_pred_pkg.sv
// Branch predictor types: operation class, decoded branch, table entry and counters.
`default_nettype none
`include "bp_config.svh"

package branch_pred_pkg;
    import riscv_isa_pkg::*;

    // Table geometry derived from the entry count.
    localparam int BT_INDEX_W = $clog2(`BRANCH_TABLE_ENTRIES);
    localparam int BT_TAG_W   = 30 - BT_INDEX_W;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_COND,
        BR_JAL,
        BR_JALR
    } branch_op_t;

    typedef struct packed {
        branch_op_t   op;
        branch_cond_t cond;
        logic [31:0]  imm;
        logic         is_call;
        logic         is_return;
    } decoded_branch_t;

    typedef struct packed {
        logic                valid;
        logic [BT_TAG_W-1:0] tag;
        logic                prediction;
        logic                use_ras;
    } bt_entry_t;

    typedef logic [31:0] miss_count_t;

endpackage

`default_nettype wire

// File: rtl/riscv_isa_pkg.sv
// RV32I instruction-set types used by the branch unit.
`default_nettype none

package riscv_isa_pkg;

    // Byte address.
    typedef logic [31:0] addr_t;

    // Register number.
    typedef logic [4:0] reg_idx_t;

    // Major opcodes that matter for control flow.
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_OTHER  = 7'b0000000
    } opcode_t;

    // funct3 of conditional branches.
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_cond_t;

    // Standard link registers.
    localparam reg_idx_t LINK_REG_RA = 5'd1;
    localparam reg_idx_t LINK_REG_T0 = 5'd5;

endpackage

`default_nettype wire

// File: include/bp_config.svh
// Branch unit configuration: table size, return stack depth and predictor mode.
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// Number of target table entries, a power of two.
`define BRANCH_TABLE_ENTRIES 64

// Number of return address stack entries, a power of two.
`define RAS_DEPTH 8

// 1 flushes only on a misprediction.
// 0 flushes on every taken branch and never predicts.
`define USE_BRANCH_PREDICTOR 1

`endif
